/* Bender.yml */
package:
  name: can_host

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/can_pkg.sv
      - src/can_addr_decode.sv
      - src/can_regs.sv
      - src/can_tx_buffer.sv
      - src/can_bit_timing.sv
      - src/can_read_mux.sv
      - src/can_host_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - tb/can_host_tb.sv

/* files.f */
+incdir+src
src/can_pkg.sv
src/can_addr_decode.sv
src/can_regs.sv
src/can_tx_buffer.sv
src/can_bit_timing.sv
src/can_read_mux.sv
src/can_host_top.sv
tb/can_host_tb.sv

/* src/can_addr_decode.sv */
`timescale 1ns/1ps
`include "can_defs.svh"

module can_addr_decode (
  input  can_pkg::can_mode_t          mode_i,
  input  logic [`CAN_ADDR_W-1:0]      addr_read_i,
  input  logic [`CAN_ADDR_W-1:0]      addr_write_i,
  output can_pkg::can_sel_t           rd_sel_o,
  output can_pkg::can_sel_t           wr_sel_o
);

  import can_pkg::*;

  // One address through the basic or extended map
  function automatic can_sel_t decode_addr(input logic [`CAN_ADDR_W-1:0] addr,
                                           input can_mode_t              mode);
    can_sel_t sel;
    logic     x_win;
    logic     b_win;
    sel         = '0;
    sel.reg_sel = REG_NONE;
    // Extended window only outside reset mode
    x_win = mode.extended_mode && !mode.reset_mode &&
            (addr >= `CAN_WIN_X_LO) && (addr <= `CAN_WIN_X_HI);
    b_win = !mode.extended_mode &&
            (addr >= `CAN_WIN_B_LO) && (addr <= `CAN_WIN_B_HI);
    sel.win_hit = x_win || b_win;
    if (x_win)
      sel.win_idx = `CAN_TXBUF_AW'(addr - `CAN_WIN_X_LO);
    else if (b_win)
      sel.win_idx = `CAN_TXBUF_AW'(addr - `CAN_WIN_B_LO);
    // Registers present in both maps
    case (addr)
      `CAN_ADDR_MODE:   sel.reg_sel = REG_MODE;
      `CAN_ADDR_BTR0:   sel.reg_sel = REG_BTR0;
      `CAN_ADDR_BTR1:   sel.reg_sel = REG_BTR1;
      `CAN_ADDR_CLKDIV: sel.reg_sel = REG_CLKDIV;
      default:          sel.reg_sel = REG_NONE;
    endcase
    if (!mode.extended_mode)
    begin
      // Basic map has a single acceptance byte pair
      if (addr == `CAN_ADDR_ACC_CODE_B)
        sel.reg_sel = REG_ACC_CODE;
      else if (addr == `CAN_ADDR_ACC_MASK_B)
        sel.reg_sel = REG_ACC_MASK;
    end
    else if (!x_win)
    begin
      // Four code bytes then four mask bytes, hidden while the window is open
      if ((addr >= `CAN_ADDR_ACC_CODE_X) && (addr < `CAN_ADDR_ACC_MASK_X))
        sel.reg_sel = REG_ACC_CODE;
      else if ((addr >= `CAN_ADDR_ACC_MASK_X) && (addr < `CAN_ADDR_ACC_MASK_X + 8'd4))
        sel.reg_sel = REG_ACC_MASK;
      // Both groups start on a multiple of four
      sel.byte_idx = addr[1:0];
    end
    return sel;
  endfunction

  // Read and write addresses decode independently
  assign rd_sel_o = decode_addr(addr_read_i, mode_i);
  assign wr_sel_o = decode_addr(addr_write_i, mode_i);

endmodule

/* src/can_bit_timing.sv */
`timescale 1ns/1ps

module can_bit_timing (
  input  logic                 clk_i,
  input  logic                 rst,
  input  logic                 rx_i,
  input  can_pkg::can_timing_t timing_i,
  input  logic                 reset_mode_i,
  output logic                 sample_point_o,
  output logic                 sampled_bit_o
);

  import can_pkg::*;

  logic       rx_meta_q;
  logic       rx_sync_q;
  logic [6:0] clk_cnt_q;
  logic       tq_end;
  can_seg_e   seg_q;
  logic [3:0] tq_cnt_q;
  logic       seg1_last;
  logic       seg2_last;
  logic       sample_q;
  logic       bit_q;

  ////////////////////////////////////////////////////////////////////////////
  // Receive line synchronizer
  ////////////////////////////////////////////////////////////////////////////

  // Idle bus is recessive
  always_ff @(posedge clk_i or posedge rst)
  begin
    if (rst)
    begin
      rx_meta_q <= 1'b1;
      rx_sync_q <= 1'b1;
    end
    else
    begin
      rx_meta_q <= rx_i;
      rx_sync_q <= rx_meta_q;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Quantum prescaler and segment FSM
  ////////////////////////////////////////////////////////////////////////////

  // Quantum is 2*(brp+1) clocks, last count is 2*brp+1
  assign tq_end = (clk_cnt_q == {timing_i.brp, 1'b1});

  // Segment ends on its last quantum
  assign seg1_last = (seg_q == SEG_TSEG1) && tq_end && (tq_cnt_q == timing_i.ts1);
  assign seg2_last = (seg_q == SEG_TSEG2) && tq_end && (tq_cnt_q == {1'b0, timing_i.ts2});

  always_ff @(posedge clk_i or posedge rst)
  begin
    if (rst)
    begin
      clk_cnt_q <= '0;
      tq_cnt_q  <= '0;
      seg_q     <= SEG_SYNC;
    end
    else if (reset_mode_i)
    begin
      // Held at the start of a bit
      clk_cnt_q <= '0;
      tq_cnt_q  <= '0;
      seg_q     <= SEG_SYNC;
    end
    else
    begin
      clk_cnt_q <= tq_end ? 7'd0 : clk_cnt_q + 7'd1;
      if (tq_end)
      begin
        case (seg_q)
          SEG_SYNC:
          begin
            seg_q    <= SEG_TSEG1;
            tq_cnt_q <= '0;
          end
          SEG_TSEG1:
            if (seg1_last)
            begin
              seg_q    <= SEG_TSEG2;
              tq_cnt_q <= '0;
            end
            else
              tq_cnt_q <= tq_cnt_q + 4'd1;
          SEG_TSEG2:
            if (seg2_last)
            begin
              seg_q    <= SEG_SYNC;
              tq_cnt_q <= '0;
            end
            else
              tq_cnt_q <= tq_cnt_q + 4'd1;
          default:
          begin
            seg_q    <= SEG_SYNC;
            tq_cnt_q <= '0;
          end
        endcase
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Sample point
  ////////////////////////////////////////////////////////////////////////////

  // Pulse and captured bit appear together, one clock after TSEG1 ends
  always_ff @(posedge clk_i or posedge rst)
  begin
    if (rst)
    begin
      sample_q <= 1'b0;
      bit_q    <= 1'b1;
    end
    else
    begin
      sample_q <= seg1_last && !reset_mode_i;
      if (seg1_last && !reset_mode_i)
        bit_q <= rx_sync_q;
    end
  end

  assign sample_point_o = sample_q;
  assign sampled_bit_o  = bit_q;

endmodule

/* src/can_defs.svh */
`ifndef CAN_DEFS_SVH
`define CAN_DEFS_SVH

// Data and address widths of the host register port
`define CAN_DATA_W 8
`define CAN_ADDR_W 8

// Transmit buffer size and index width
`define CAN_TXBUF_DEPTH 13
`define CAN_TXBUF_AW 4

// Register addresses shared by both maps
`define CAN_ADDR_MODE 8'd0
`define CAN_ADDR_BTR0 8'd6
`define CAN_ADDR_BTR1 8'd7
`define CAN_ADDR_CLKDIV 8'd31

// Acceptance bytes, basic map (one byte each)
`define CAN_ADDR_ACC_CODE_B 8'd4
`define CAN_ADDR_ACC_MASK_B 8'd5

// Acceptance bytes, extended map (first of four bytes each)
`define CAN_ADDR_ACC_CODE_X 8'd16
`define CAN_ADDR_ACC_MASK_X 8'd20

// Read window bounds per map
`define CAN_WIN_X_LO 8'd16
`define CAN_WIN_X_HI 8'd28
`define CAN_WIN_B_LO 8'd20
`define CAN_WIN_B_HI 8'd29

// Mode register comes up in reset mode
`define CAN_MODE_RST_VAL 8'h01

`endif

/* src/can_host_top.sv */
`timescale 1ns/1ps
`include "can_defs.svh"

module can_host_top (
  input  logic                        clk_i,
  input  logic                        rst,
  // Register port
  input  logic                        reg_we_i,
  input  logic                        reg_re_i,
  input  logic [`CAN_ADDR_W-1:0]      reg_addr_write_i,
  input  logic [`CAN_ADDR_W-1:0]      reg_addr_read_i,
  input  logic [`CAN_DATA_W-1:0]      reg_data_i,
  output logic [`CAN_DATA_W-1:0]      reg_data_o,
  // Transmit buffer port
  input  logic                        tx_we_i,
  input  logic [`CAN_TXBUF_AW-1:0]    tx_addr_i,
  input  logic [`CAN_DATA_W-1:0]      tx_data_i,
  // Receive line and bit timing
  input  logic                        rx_i,
  output logic                        sample_point_o,
  output logic                        sampled_bit_o
);

  import can_pkg::*;

  can_mode_t              mode;
  can_timing_t            timing;
  can_sel_t               wr_sel;
  can_sel_t               rd_sel;
  logic [`CAN_DATA_W-1:0] reg_byte;
  logic [`CAN_DATA_W-1:0] win_byte;

  ////////////////////////////////////////////////////////////////////////////
  // Decode
  ////////////////////////////////////////////////////////////////////////////

  can_addr_decode addr_decode_i (
    .mode_i       (mode),
    .addr_read_i  (reg_addr_read_i),
    .addr_write_i (reg_addr_write_i),
    .rd_sel_o     (rd_sel),
    .wr_sel_o     (wr_sel)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Execute
  ////////////////////////////////////////////////////////////////////////////

  can_regs regs_i (
    .clk_i    (clk_i),
    .rst      (rst),
    .we_i     (reg_we_i),
    .wr_sel_i (wr_sel),
    .rd_sel_i (rd_sel),
    .data_i   (reg_data_i),
    .data_o   (reg_byte),
    .mode_o   (mode),
    .timing_o (timing)
  );

  // Window reads the transmit buffer
  can_tx_buffer tx_buffer_i (
    .clk_i        (clk_i),
    .rst          (rst),
    .we_i         (tx_we_i),
    .addr_i       (tx_addr_i),
    .data_i       (tx_data_i),
    .reset_mode_i (mode.reset_mode),
    .rd_idx_i     (rd_sel.win_idx),
    .rd_data_o    (win_byte)
  );

  can_bit_timing bit_timing_i (
    .clk_i          (clk_i),
    .rst            (rst),
    .rx_i           (rx_i),
    .timing_i       (timing),
    .reset_mode_i   (mode.reset_mode),
    .sample_point_o (sample_point_o),
    .sampled_bit_o  (sampled_bit_o)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Result
  ////////////////////////////////////////////////////////////////////////////

  can_read_mux read_mux_i (
    .clk_i      (clk_i),
    .rst        (rst),
    .re_i       (reg_re_i),
    .win_hit_i  (rd_sel.win_hit),
    .reg_data_i (reg_byte),
    .win_data_i (win_byte),
    .data_o     (reg_data_o)
  );

endmodule

/* src/can_pkg.sv */
`include "can_defs.svh"

package can_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Enumerations
  ////////////////////////////////////////////////////////////////////////////

  // Register selected by an address decode
  typedef enum logic [2:0] {
    REG_NONE,
    REG_MODE,
    REG_BTR0,
    REG_BTR1,
    REG_CLKDIV,
    REG_ACC_CODE,
    REG_ACC_MASK
  } can_reg_e;

  // Bit-timing segment states
  typedef enum logic [1:0] {
    SEG_SYNC,
    SEG_TSEG1,
    SEG_TSEG2
  } can_seg_e;

  ////////////////////////////////////////////////////////////////////////////
  // Structs
  ////////////////////////////////////////////////////////////////////////////

  // Bus timing 0 in the upper byte, bus timing 1 in the lower byte
  typedef struct packed {
    logic [1:0] sjw;  // kept in the register, no resync logic behind it
    logic [5:0] brp;
    logic       sam;  // kept in the register, single sampling only
    logic [2:0] ts2;
    logic [3:0] ts1;
  } can_timing_t;

  // Operating mode bits
  typedef struct packed {
    logic reset_mode;
    logic extended_mode;
  } can_mode_t;

  // Result of one address decode
  typedef struct packed {
    can_reg_e                   reg_sel;
    logic [1:0]                 byte_idx;
    logic                       win_hit;
    logic [`CAN_TXBUF_AW-1:0]   win_idx;
  } can_sel_t;

endpackage

/* src/can_read_mux.sv */
`timescale 1ns/1ps
`include "can_defs.svh"

module can_read_mux (
  input  logic                        clk_i,
  input  logic                        rst,
  input  logic                        re_i,
  input  logic                        win_hit_i,
  input  logic [`CAN_DATA_W-1:0]      reg_data_i,
  input  logic [`CAN_DATA_W-1:0]      win_data_i,
  output logic [`CAN_DATA_W-1:0]      data_o
);

  logic [`CAN_DATA_W-1:0] data_q;

  // Capture on the read strobe, hold otherwise
  always_ff @(posedge clk_i or posedge rst)
  begin
    if (rst)
    begin
      data_q <= '0;
    end
    else if (re_i)
    begin
      // Window takes priority over the register file
      if (win_hit_i)
        data_q <= win_data_i;
      else
        data_q <= reg_data_i;
    end
  end

  assign data_o = data_q;

endmodule

/* src/can_regs.sv */
`timescale 1ns/1ps
`include "can_defs.svh"

module can_regs (
  input  logic                        clk_i,
  input  logic                        rst,
  input  logic                        we_i,
  input  can_pkg::can_sel_t           wr_sel_i,
  input  can_pkg::can_sel_t           rd_sel_i,
  input  logic [`CAN_DATA_W-1:0]      data_i,
  output logic [`CAN_DATA_W-1:0]      data_o,
  output can_pkg::can_mode_t          mode_o,
  output can_pkg::can_timing_t        timing_o
);

  import can_pkg::*;

  localparam logic [`CAN_DATA_W-1:0] MODE_RST = `CAN_MODE_RST_VAL;

  can_mode_t                     mode_q;
  can_timing_t                   timing_q;
  logic [3:0][`CAN_DATA_W-1:0]   acc_code_q;
  logic [3:0][`CAN_DATA_W-1:0]   acc_mask_q;

  ////////////////////////////////////////////////////////////////////////////
  // Register writes
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or posedge rst)
  begin
    if (rst)
    begin
      mode_q.reset_mode    <= MODE_RST[0];
      mode_q.extended_mode <= 1'b0;
      timing_q             <= '0;
      acc_code_q           <= '0;
      acc_mask_q           <= '0;
    end
    else if (we_i)
    begin
      case (wr_sel_i.reg_sel)
        // Mode and clock divider always writable
        REG_MODE:   mode_q.reset_mode    <= data_i[0];
        REG_CLKDIV: mode_q.extended_mode <= data_i[7];
        // Timing and acceptance only while in reset mode
        REG_BTR0:
          if (mode_q.reset_mode)
          begin
            timing_q.sjw <= data_i[7:6];
            timing_q.brp <= data_i[5:0];
          end
        REG_BTR1:
          if (mode_q.reset_mode)
          begin
            timing_q.sam <= data_i[7];
            timing_q.ts2 <= data_i[6:4];
            timing_q.ts1 <= data_i[3:0];
          end
        REG_ACC_CODE:
          if (mode_q.reset_mode)
            acc_code_q[wr_sel_i.byte_idx] <= data_i;
        REG_ACC_MASK:
          if (mode_q.reset_mode)
            acc_mask_q[wr_sel_i.byte_idx] <= data_i;
        default: ;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Register readback
  ////////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    case (rd_sel_i.reg_sel)
      REG_MODE:     data_o = {7'd0, mode_q.reset_mode};
      REG_BTR0:     data_o = {timing_q.sjw, timing_q.brp};
      REG_BTR1:     data_o = {timing_q.sam, timing_q.ts2, timing_q.ts1};
      REG_CLKDIV:   data_o = {mode_q.extended_mode, 7'd0};
      REG_ACC_CODE: data_o = acc_code_q[rd_sel_i.byte_idx];
      REG_ACC_MASK: data_o = acc_mask_q[rd_sel_i.byte_idx];
      // Unmapped addresses read zero
      default:      data_o = '0;
    endcase
  end

  assign mode_o   = mode_q;
  assign timing_o = timing_q;

endmodule

/* src/can_tx_buffer.sv */
`timescale 1ns/1ps
`include "can_defs.svh"

module can_tx_buffer (
  input  logic                        clk_i,
  input  logic                        rst,
  input  logic                        we_i,
  input  logic [`CAN_TXBUF_AW-1:0]    addr_i,
  input  logic [`CAN_DATA_W-1:0]      data_i,
  input  logic                        reset_mode_i,
  input  logic [`CAN_TXBUF_AW-1:0]    rd_idx_i,
  output logic [`CAN_DATA_W-1:0]      rd_data_o
);

  logic [`CAN_DATA_W-1:0] buf_q [`CAN_TXBUF_DEPTH];
  logic                   wr_ok;

  // Buffer is locked in reset mode, indices past the end are dropped
  assign wr_ok = we_i && !reset_mode_i && (addr_i < `CAN_TXBUF_AW'(`CAN_TXBUF_DEPTH));

  always_ff @(posedge clk_i or posedge rst)
  begin
    if (rst)
    begin
      for (int i = 0; i < `CAN_TXBUF_DEPTH; i++)
        buf_q[i] <= '0;
    end
    else if (wr_ok)
    begin
      buf_q[addr_i] <= data_i;
    end
  end

  // Indexed readback for the read window
  always_comb
  begin
    if (rd_idx_i < `CAN_TXBUF_AW'(`CAN_TXBUF_DEPTH))
      rd_data_o = buf_q[rd_idx_i];
    else
      rd_data_o = '0;
  end

endmodule

/* tb/can_host_tb.sv */
`timescale 1ns/1ps
`include "can_defs.svh"

module can_host_tb;

  ////////////////////////////////////////////////////////////////////////////
  // Constants and types
  ////////////////////////////////////////////////////////////////////////////

  localparam int RESET_CYCLES = 16;
  localparam int TAB_MAX      = 128;
  localparam int NUM_CFG      = 4;

  // Table operations
  localparam logic [1:0] OP_REG_WR = 2'd0;
  localparam logic [1:0] OP_TX_WR  = 2'd1;
  localparam logic [1:0] OP_RD_CHK = 2'd2;
  localparam logic [1:0] OP_NO_SP  = 2'd3;

  // One table row with its name kept in a parallel array
  typedef struct packed {
    logic [1:0] op;
    logic [7:0] addr;
    logic [7:0] data;
    logic [7:0] exp;
  } entry_t;

  // One bit-timing setup for the sample-point checks
  typedef struct packed {
    logic [5:0] brp;
    logic [3:0] ts1;
    logic [2:0] ts2;
    logic       level;
  } cfg_t;

  ////////////////////////////////////////////////////////////////////////////
  // DUT signals
  ////////////////////////////////////////////////////////////////////////////

  logic       clk_i;
  logic       rst;
  logic       reg_we_i;
  logic       reg_re_i;
  logic [7:0] reg_addr_write_i;
  logic [7:0] reg_addr_read_i;
  logic [7:0] reg_data_i;
  logic [7:0] reg_data_o;
  logic       tx_we_i;
  logic [3:0] tx_addr_i;
  logic [7:0] tx_data_i;
  logic       rx_i;
  logic       sample_point_o;
  logic       sampled_bit_o;

  entry_t tab [0:TAB_MAX-1];
  string  tab_name [0:TAB_MAX-1];
  int     tab_len;
  cfg_t   cfgs [0:NUM_CFG-1];
  int     pass_cnt;
  int     fail_cnt;
  int     cycle_cnt;
  int     cycle_limit;
  int     pulse_cnt;

  can_host_top dut_i (
    .clk_i            (clk_i),
    .rst              (rst),
    .reg_we_i         (reg_we_i),
    .reg_re_i         (reg_re_i),
    .reg_addr_write_i (reg_addr_write_i),
    .reg_addr_read_i  (reg_addr_read_i),
    .reg_data_i       (reg_data_i),
    .reg_data_o       (reg_data_o),
    .tx_we_i          (tx_we_i),
    .tx_addr_i        (tx_addr_i),
    .tx_data_i        (tx_data_i),
    .rx_i             (rx_i),
    .sample_point_o   (sample_point_o),
    .sampled_bit_o    (sampled_bit_o)
  );

  // 10 ns clock
  initial clk_i = 1'b0;
  always #5 clk_i = ~clk_i;

  // Cycle counter and watchdog
  always @(posedge clk_i)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if ((cycle_limit > 0) && (cycle_cnt >= cycle_limit))
    begin
      $display("Timeout after %0d cycles, the DUT stopped making progress", cycle_cnt);
      $display("Result: FAILED");
      $finish;
    end
  end

  // Sample pulses counted mid-cycle where the output is stable
  always @(negedge clk_i)
  begin
    if (sample_point_o)
      pulse_cnt <= pulse_cnt + 1;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [7:0] rand_byte();
    logic [31:0] r;
    r = $urandom();
    return r[7:0];
  endfunction

  task automatic add_entry(input string name, input logic [1:0] op, input logic [7:0] addr,
                           input logic [7:0] data, input logic [7:0] exp);
    tab_name[tab_len] = name;
    tab[tab_len]      = {op, addr, data, exp};
    tab_len++;
  endtask

  // Drivers start 1 ns after a rising edge and end 1 ns after the next
  task automatic write_reg(input logic [7:0] addr, input logic [7:0] data);
    reg_addr_write_i = addr;
    reg_data_i       = data;
    reg_we_i         = 1'b1;
    @(posedge clk_i);
    #1;
    reg_we_i = 1'b0;
  endtask

  task automatic write_txbuf(input logic [3:0] idx, input logic [7:0] data);
    tx_addr_i = idx;
    tx_data_i = data;
    tx_we_i   = 1'b1;
    @(posedge clk_i);
    #1;
    tx_we_i = 1'b0;
  endtask

  // Read data is registered on the strobe edge
  task automatic read_reg(input logic [7:0] addr, output logic [7:0] got);
    reg_addr_read_i = addr;
    reg_re_i        = 1'b1;
    @(posedge clk_i);
    #1;
    reg_re_i = 1'b0;
    got      = reg_data_o;
  endtask

  task automatic check_value(input string name, input logic [7:0] exp, input logic [7:0] act);
    assert (act === exp)
    begin
      pass_cnt++;
      $display("[PASS] %s", name);
    end
    else
    begin
      fail_cnt++;
      $display("[FAIL] %s expected 0x%02h actual 0x%02h", name, exp, act);
    end
  endtask

  task automatic verify_count(input string name, input int exp, input int act);
    assert (act == exp)
    begin
      pass_cnt++;
      $display("[PASS] %s", name);
    end
    else
    begin
      fail_cnt++;
      $display("[FAIL] %s expected %0d actual %0d", name, exp, act);
    end
  endtask

  // Returns the cycle number of the next sample pulse
  task automatic wait_pulse(output int stamp);
    do
    begin
      @(posedge clk_i);
      #1;
    end
    while (!sample_point_o);
    stamp = cycle_cnt;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial
  begin
    logic [7:0]  btr0_v;
    logic [7:0]  btr1_v;
    logic [7:0]  code_v;
    logic [7:0]  mask_v;
    logic [7:0]  acc_v [0:7];
    logic [7:0]  buf_v [0:12];
    logic [7:0]  got;
    entry_t      e;
    int          t0;
    int          t1;
    int          per;
    int          max_period;

    rst              = 1'b1;
    reg_we_i         = 1'b0;
    reg_re_i         = 1'b0;
    reg_addr_write_i = '0;
    reg_addr_read_i  = '0;
    reg_data_i       = '0;
    tx_we_i          = 1'b0;
    tx_addr_i        = '0;
    tx_data_i        = '0;
    rx_i             = 1'b1;
    pass_cnt         = 0;
    fail_cnt         = 0;
    cycle_cnt        = 0;
    cycle_limit      = 0;
    pulse_cnt        = 0;
    tab_len          = 0;
    void'($urandom(20));

    // Reset values with the window reading the empty buffer
    add_entry("rst_mode", OP_RD_CHK, `CAN_ADDR_MODE, 8'h00, `CAN_MODE_RST_VAL);
    add_entry("rst_btr0", OP_RD_CHK, `CAN_ADDR_BTR0, 8'h00, 8'h00);
    add_entry("rst_btr1", OP_RD_CHK, `CAN_ADDR_BTR1, 8'h00, 8'h00);
    add_entry("rst_clkdiv", OP_RD_CHK, `CAN_ADDR_CLKDIV, 8'h00, 8'h00);
    add_entry("rst_acc_code", OP_RD_CHK, `CAN_ADDR_ACC_CODE_B, 8'h00, 8'h00);
    add_entry("rst_acc_mask", OP_RD_CHK, `CAN_ADDR_ACC_MASK_B, 8'h00, 8'h00);
    add_entry("rst_win_lo", OP_RD_CHK, `CAN_WIN_B_LO, 8'h00, 8'h00);
    add_entry("rst_win_hi", OP_RD_CHK, `CAN_WIN_B_HI, 8'h00, 8'h00);

    // Basic map writes in reset mode
    btr0_v = rand_byte();
    btr1_v = rand_byte();
    code_v = rand_byte();
    mask_v = rand_byte();
    add_entry("wr_btr0", OP_REG_WR, `CAN_ADDR_BTR0, btr0_v, 8'h00);
    add_entry("wr_btr1", OP_REG_WR, `CAN_ADDR_BTR1, btr1_v, 8'h00);
    add_entry("wr_acc_code", OP_REG_WR, `CAN_ADDR_ACC_CODE_B, code_v, 8'h00);
    add_entry("wr_acc_mask", OP_REG_WR, `CAN_ADDR_ACC_MASK_B, mask_v, 8'h00);
    add_entry("rd_btr0", OP_RD_CHK, `CAN_ADDR_BTR0, 8'h00, btr0_v);
    add_entry("rd_btr1", OP_RD_CHK, `CAN_ADDR_BTR1, 8'h00, btr1_v);
    add_entry("rd_acc_code", OP_RD_CHK, `CAN_ADDR_ACC_CODE_B, 8'h00, code_v);
    add_entry("rd_acc_mask", OP_RD_CHK, `CAN_ADDR_ACC_MASK_B, 8'h00, mask_v);
    add_entry("no_sample_in_reset", OP_NO_SP, 8'h00, 8'h00, 8'h00);

    // Buffer locked in reset mode and config locked outside it
    // Blocked writes carry data that differs from what is stored
    add_entry("tx_in_reset", OP_TX_WR, 8'd0, rand_byte() | 8'h01, 8'h00);
    add_entry("clr_reset_mode", OP_REG_WR, `CAN_ADDR_MODE, 8'h00, 8'h00);
    add_entry("wr_btr0_locked", OP_REG_WR, `CAN_ADDR_BTR0, ~btr0_v, 8'h00);
    add_entry("wr_btr1_locked", OP_REG_WR, `CAN_ADDR_BTR1, ~btr1_v, 8'h00);
    add_entry("wr_code_locked", OP_REG_WR, `CAN_ADDR_ACC_CODE_B, ~code_v, 8'h00);
    add_entry("wr_mask_locked", OP_REG_WR, `CAN_ADDR_ACC_MASK_B, ~mask_v, 8'h00);
    add_entry("keep_btr0", OP_RD_CHK, `CAN_ADDR_BTR0, 8'h00, btr0_v);
    add_entry("keep_btr1", OP_RD_CHK, `CAN_ADDR_BTR1, 8'h00, btr1_v);
    add_entry("keep_acc_code", OP_RD_CHK, `CAN_ADDR_ACC_CODE_B, 8'h00, code_v);
    add_entry("keep_acc_mask", OP_RD_CHK, `CAN_ADDR_ACC_MASK_B, 8'h00, mask_v);
    add_entry("mode_cleared", OP_RD_CHK, `CAN_ADDR_MODE, 8'h00, 8'h00);
    add_entry("tx_locked", OP_RD_CHK, `CAN_WIN_B_LO, 8'h00, 8'h00);

    // Extended map acceptance bytes followed by the window
    add_entry("set_reset_mode", OP_REG_WR, `CAN_ADDR_MODE, 8'h01, 8'h00);
    add_entry("set_ext", OP_REG_WR, `CAN_ADDR_CLKDIV, 8'h80, 8'h00);
    add_entry("rd_clkdiv", OP_RD_CHK, `CAN_ADDR_CLKDIV, 8'h00, 8'h80);
    for (int i = 0; i < 8; i++)
    begin
      acc_v[i] = rand_byte();
      add_entry($sformatf("wr_acc_x%0d", i), OP_REG_WR, `CAN_ADDR_ACC_CODE_X + i, acc_v[i],
                8'h00);
    end
    for (int i = 0; i < 8; i++)
      add_entry($sformatf("rd_acc_x%0d", i), OP_RD_CHK, `CAN_ADDR_ACC_CODE_X + i, 8'h00,
                acc_v[i]);
    add_entry("clr_reset_mode_x", OP_REG_WR, `CAN_ADDR_MODE, 8'h00, 8'h00);
    for (int i = 0; i < 13; i++)
    begin
      buf_v[i] = rand_byte();
      add_entry($sformatf("wr_tx%0d", i), OP_TX_WR, i, buf_v[i], 8'h00);
    end
    for (int i = 0; i < 13; i++)
      add_entry($sformatf("rd_win_x%0d", i), OP_RD_CHK, `CAN_WIN_X_LO + i, 8'h00, buf_v[i]);

    // Basic window shows the first ten bytes
    add_entry("clr_ext", OP_REG_WR, `CAN_ADDR_CLKDIV, 8'h00, 8'h00);
    for (int i = 0; i < 10; i++)
      add_entry($sformatf("rd_win_b%0d", i), OP_RD_CHK, `CAN_WIN_B_LO + i, 8'h00, buf_v[i]);
    add_entry("unmapped_3", OP_RD_CHK, 8'd3, 8'h00, 8'h00);
    add_entry("unmapped_30", OP_RD_CHK, 8'd30, 8'h00, 8'h00);

    // Timing setups as brp ts1 ts2 level
    cfgs[0] = {6'd1, 4'd3, 3'd2, 1'b0};
    cfgs[1] = {6'd0, 4'd5, 3'd1, 1'b1};
    cfgs[2] = {6'd2, 4'd2, 3'd1, 1'b1};
    cfgs[3] = {6'd0, 4'd1, 3'd0, 1'b0};
    max_period = 0;
    for (int c = 0; c < NUM_CFG; c++)
    begin
      per = 2 * (cfgs[c].brp + 1) * (cfgs[c].ts1 + cfgs[c].ts2 + 3);
      if (per > max_period)
        max_period = per;
    end
    // Four cycles per table row plus four writes and three bit periods per setup
    cycle_limit = tab_len * 4 + NUM_CFG * (16 + 3 * max_period) + RESET_CYCLES;

    repeat (RESET_CYCLES) @(posedge clk_i);
    #1;
    rst = 1'b0;

    for (int k = 0; k < tab_len; k++)
    begin
      e = tab[k];
      case (e.op)
        OP_REG_WR: write_reg(e.addr, e.data);
        OP_TX_WR:  write_txbuf(e.addr[3:0], e.data);
        OP_RD_CHK:
        begin
          read_reg(e.addr, got);
          check_value(tab_name[k], e.exp, got);
        end
        default:   verify_count(tab_name[k], 0, pulse_cnt);
      endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Sample-point spacing and captured level
    ////////////////////////////////////////////////////////////////////////////

    for (int c = 0; c < NUM_CFG; c++)
    begin
      write_reg(`CAN_ADDR_MODE, 8'h01);
      write_reg(`CAN_ADDR_BTR0, {2'b00, cfgs[c].brp});
      write_reg(`CAN_ADDR_BTR1, {1'b0, cfgs[c].ts2, cfgs[c].ts1});
      rx_i = cfgs[c].level;
      write_reg(`CAN_ADDR_MODE, 8'h00);
      per = 2 * (cfgs[c].brp + 1) * (cfgs[c].ts1 + cfgs[c].ts2 + 3);
      wait_pulse(t0);
      check_value($sformatf("sp%0d_bit0", c), {7'd0, cfgs[c].level}, {7'd0, sampled_bit_o});
      for (int p = 1; p < 3; p++)
      begin
        wait_pulse(t1);
        verify_count($sformatf("sp%0d_period%0d", c, p), per, t1 - t0);
        check_value($sformatf("sp%0d_bit%0d", c, p), {7'd0, cfgs[c].level},
                    {7'd0, sampled_bit_o});
        t0 = t1;
      end
    end

    $display("Summary: %0d passed, %0d failed", pass_cnt, fail_cnt);
    if (fail_cnt == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

endmodule
